// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       := ex_stage_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verification/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/ex_alu.sv
`default_nettype none

module ex_alu (
  input  ex_isa_pkg::alu_op_e            operator_i,
  input  logic [ex_pipe_pkg::data_w-1:0] operand_a_i,
  input  logic [ex_pipe_pkg::data_w-1:0] operand_b_i,
  output logic [ex_pipe_pkg::data_w-1:0] result_o,
  output logic                           cmp_result_o
);

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  logic [data_w-1:0] add_result;
  logic [data_w:0]   sub_result;
  logic              lt_u;
  logic              lt_s;
  logic              eq;
  logic [4:0]        shamt;
  logic              cmp_bit;

  //////////////////////////////////////////////////////////////////////
  // Adder and comparator
  //////////////////////////////////////////////////////////////////////

  assign add_result = operand_a_i + operand_b_i;

  // One extra bit so the borrow shows up at the top
  assign sub_result = {1'b0, operand_a_i} - {1'b0, operand_b_i};

  // Borrow out means a < b unsigned
  assign lt_u = sub_result[data_w];

  // Signs differ so a is less exactly when it is negative
  // Same sign means the difference cannot overflow
  assign lt_s = (operand_a_i[data_w-1] ^ operand_b_i[data_w-1]) ?
                operand_a_i[data_w-1] : sub_result[data_w-1];

  assign eq = (operand_a_i == operand_b_i);

  // Shift amount from operand b only
  assign shamt = operand_b_i[4:0];

  // Comparison bit for set and branch operators
  always_comb begin
    cmp_bit = 1'b0;
    case (operator_i)
      EQ:        cmp_bit = eq;
      NE:        cmp_bit = ~eq;
      LT, SLT:   cmp_bit = lt_s;
      GE:        cmp_bit = ~lt_s;
      LTU, SLTU: cmp_bit = lt_u;
      GEU:       cmp_bit = ~lt_u;
      // Everything else is not a compare
      default:   cmp_bit = 1'b0;
    endcase
  end

  // Low for non-comparison operators
  assign cmp_result_o = cmp_bit;

  //////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ADD:     result_o = add_result;
      SUB:     result_o = sub_result[data_w-1:0];
      AND:     result_o = operand_a_i & operand_b_i;
      OR:      result_o = operand_a_i | operand_b_i;
      XOR:     result_o = operand_a_i ^ operand_b_i;
      SLL:     result_o = operand_a_i << shamt;
      SRL:     result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      SRA:     result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compares return the bit zero-extended
      default: result_o = {{(data_w-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

// File: logic/ex_isa_pkg.sv
`default_nettype none

package ex_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // ALU operators
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    // Arithmetic and logic
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    // Shifts by the low five bits of operand b
    SLL  = 4'h5,
    SRL  = 4'h6,
    SRA  = 4'h7,
    // Set on less than
    SLT  = 4'h8,
    SLTU = 4'h9,
    // Branch compares
    EQ   = 4'ha,
    NE   = 4'hb,
    LT   = 4'hc,
    GE   = 4'hd,
    LTU  = 4'he,
    GEU  = 4'hf
  } alu_op_e;

  // Multiplier operators
  // High word variants differ only in operand signedness
  typedef enum logic [1:0] {
    MUL    = 2'b00,
    MULH   = 2'b01,
    MULHSU = 2'b10,
    MULHU  = 2'b11
  } mult_op_e;

endpackage

`default_nettype wire

// File: logic/ex_mult.sv
`default_nettype none

module ex_mult (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           enable_i,
  input  ex_isa_pkg::mult_op_e           operator_i,
  input  logic [ex_pipe_pkg::data_w-1:0] op_a_i,
  input  logic [ex_pipe_pkg::data_w-1:0] op_b_i,
  input  logic                           ex_ready_i,
  output logic [ex_pipe_pkg::data_w-1:0] result_o,
  output logic                           multicycle_o,
  output logic                           ready_o
);

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  mult_state_e         state_q;
  mult_state_e         state_d;
  logic                sign_a;
  logic                sign_b;
  logic [data_w:0]     op_a_ext;
  logic [data_w:0]     op_b_ext;
  logic [2*data_w+1:0] product_full;
  logic [2*data_w-1:0] product;
  logic [data_w-1:0]   high_q;
  logic                high_op;
  logic                high_load;

  //////////////////////////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////////////////////////

  // Operand a signed for MULH and MULHSU
  assign sign_a = (operator_i == MULH) || (operator_i == MULHSU);
  // Operand b signed for MULH only
  assign sign_b = (operator_i == MULH);

  // One extra bit lets a single signed multiply cover all three cases
  assign op_a_ext = {sign_a & op_a_i[data_w-1], op_a_i};
  assign op_b_ext = {sign_b & op_b_i[data_w-1], op_b_i};

  assign product_full = $signed(op_a_ext) * $signed(op_b_ext);

  // Only the lower 64 bits carry information
  assign product = product_full[2*data_w-1:0];

  // Any high word request stalls for one cycle
  assign high_op = enable_i & (operator_i != MUL);

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    high_load    = 1'b0;
    // MUL returns the low word straight away
    result_o     = product[data_w-1:0];
    case (state_q)
      IDLE: begin
        if (high_op) begin
          // Capture the upper word and stall the stage
          ready_o   = 1'b0;
          high_load = 1'b1;
          state_d   = HIGH;
        end
      end
      HIGH: begin
        multicycle_o = 1'b1;
        result_o     = high_q;
        // Leave once the stage takes the result
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper product word presented in HIGH
  always_ff @(posedge clk) begin
    if (high_load) begin
      high_q <= product[2*data_w-1:data_w];
    end
  end

endmodule

`default_nettype wire

// File: logic/ex_pipe_pkg.sv
`default_nettype none

package ex_pipe_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////////////////////////

  // Integer data word
  localparam int unsigned data_w = 32;

  // Register file address
  // Wide enough for the integer and floating point banks
  localparam int unsigned reg_addr_w = 6;

  //////////////////////////////////////////////////////////////////////
  // Pipeline sequencing
  //////////////////////////////////////////////////////////////////////

  // Multiplier state
  // HIGH holds the registered upper product word for one stall cycle
  typedef enum logic [0:0] {
    IDLE = 1'b0,
    HIGH = 1'b1
  } mult_state_e;

endpackage

`default_nettype wire

// File: logic/ex_stage.sv
`default_nettype none

module ex_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  // ALU
  input  logic                               alu_en_i,
  input  ex_isa_pkg::alu_op_e                alu_operator_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     alu_operand_a_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     alu_operand_b_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     alu_operand_c_i,
  // Multiplier
  input  logic                               mult_en_i,
  input  ex_isa_pkg::mult_op_e               mult_operator_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     mult_operand_a_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     mult_operand_b_i,
  // CSR and load-store unit
  input  logic                               csr_access_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     csr_rdata_i,
  input  logic                               lsu_en_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     lsu_rdata_i,
  input  logic                               lsu_ready_ex_i,
  // Decode control
  input  logic                               branch_in_ex_i,
  input  logic                               regfile_alu_we_i,
  input  logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_alu_waddr_i,
  input  logic                               regfile_we_i,
  input  logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_waddr_i,
  input  logic                               wb_ready_i,
  // Forwarding port
  output logic                               regfile_alu_we_fw_o,
  output logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pipe_pkg::data_w-1:0]     regfile_alu_wdata_fw_o,
  // Load write port
  output logic                               regfile_we_wb_o,
  output logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_waddr_wb_o,
  output logic [ex_pipe_pkg::data_w-1:0]     regfile_wdata_wb_o,
  // Branch resolution towards fetch
  output logic                               branch_decision_o,
  output logic [ex_pipe_pkg::data_w-1:0]     jump_target_o,
  // Stage status
  output logic                               mult_multicycle_o,
  output logic                               ex_ready_o,
  output logic                               ex_valid_o
);

  import ex_pipe_pkg::*;

  logic [data_w-1:0] alu_result;
  logic              alu_cmp_result;
  logic [data_w-1:0] mult_result;
  logic              mult_ready;

  // Jump target computed in decode passes through unchanged
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Stage ready closes the loop on the high word stall
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .mult_ready_i           (mult_ready),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

// File: logic/ex_writeback.sv
`default_nettype none

module ex_writeback (
  input  logic                               clk,
  input  logic                               rst_n,
  // Decode side
  input  logic                               alu_en_i,
  input  logic                               mult_en_i,
  input  logic                               csr_access_i,
  input  logic                               lsu_en_i,
  input  logic                               branch_in_ex_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     csr_rdata_i,
  input  logic                               regfile_alu_we_i,
  input  logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_alu_waddr_i,
  input  logic                               regfile_we_i,
  input  logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_waddr_i,
  // Execution units
  input  logic [ex_pipe_pkg::data_w-1:0]     alu_result_i,
  input  logic [ex_pipe_pkg::data_w-1:0]     mult_result_i,
  input  logic                               mult_ready_i,
  // Load-store unit and write-back stage
  input  logic [ex_pipe_pkg::data_w-1:0]     lsu_rdata_i,
  input  logic                               lsu_ready_ex_i,
  input  logic                               wb_ready_i,
  // Forwarding port
  output logic                               regfile_alu_we_fw_o,
  output logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pipe_pkg::data_w-1:0]     regfile_alu_wdata_fw_o,
  // Load write port
  output logic                               regfile_we_wb_o,
  output logic [ex_pipe_pkg::reg_addr_w-1:0] regfile_waddr_wb_o,
  output logic [ex_pipe_pkg::data_w-1:0]     regfile_wdata_wb_o,
  // Stage control
  output logic                               ex_ready_o,
  output logic                               ex_valid_o
);

  import ex_pipe_pkg::*;

  logic                  we_q;
  logic [reg_addr_w-1:0] waddr_q;
  logic                  units_ready;
  logic                  any_en;

  //////////////////////////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR data wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register and stall control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (ex_valid_o) begin
      // Accepted instruction
      we_q <= regfile_we_i;
      if (regfile_we_i) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new so the slot drains
      we_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  // Load data arrives from the LSU without a stage register here
  assign regfile_wdata_wb_o = lsu_rdata_i;

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve in EX and never wait on write-back
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid flows forward only and ignores ready
  assign ex_valid_o = any_en & units_ready;

endmodule

`default_nettype wire

// File: project.f
+incdir+verification
logic/ex_isa_pkg.sv
logic/ex_pipe_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_writeback.sv
logic/ex_stage.sv
verification/ex_stage_tb.sv

// File: verification/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference behavior of the execution units
//////////////////////////////////////////////////////////////////////

// Stimulus generator step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// Compare outcome is low for every non-compare operator
function automatic logic cmp_ref(input alu_op_e op, input logic [data_w-1:0] a,
                                 input logic [data_w-1:0] b);
  case (op)
    EQ:        return a == b;
    NE:        return a != b;
    LT, SLT:   return $signed(a) < $signed(b);
    GE:        return $signed(a) >= $signed(b);
    LTU, SLTU: return a < b;
    GEU:       return a >= b;
    default:   return 1'b0;
  endcase
endfunction

// ALU result word
function automatic logic [data_w-1:0] alu_ref(input alu_op_e op, input logic [data_w-1:0] a,
                                              input logic [data_w-1:0] b);
  case (op)
    ADD:     return a + b;
    SUB:     return a - b;
    AND:     return a & b;
    OR:      return a | b;
    XOR:     return a ^ b;
    SLL:     return a << b[4:0];
    SRL:     return a >> b[4:0];
    SRA:     return $signed(a) >>> b[4:0];
    // Set and branch compares give the bit in position zero
    default: return {{(data_w-1){1'b0}}, cmp_ref(op, a, b)};
  endcase
endfunction

// Multiplier result gives the low word for MUL and the high word otherwise
function automatic logic [data_w-1:0] mult_ref(input mult_op_e op, input logic [data_w-1:0] a,
                                               input logic [data_w-1:0] b);
  logic [2*data_w-1:0] ea;
  logic [2*data_w-1:0] eb;
  logic [2*data_w-1:0] p;
  // Extending to full product width makes the wrapped product exact
  ea = {{data_w{a[data_w-1] & (op == MULH || op == MULHSU)}}, a};
  eb = {{data_w{b[data_w-1] & (op == MULH)}}, b};
  p  = ea * eb;
  return (op == MUL) ? p[data_w-1:0] : p[2*data_w-1:data_w];
endfunction

`endif

// File: verification/ex_stage_tb.sv
`default_nettype none

module ex_stage_tb;

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  `include "ex_model.svh"

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  alu_en_i;
  alu_op_e               alu_operator_i;
  logic [data_w-1:0]     alu_operand_a_i;
  logic [data_w-1:0]     alu_operand_b_i;
  logic [data_w-1:0]     alu_operand_c_i;
  logic                  mult_en_i;
  mult_op_e              mult_operator_i;
  logic [data_w-1:0]     mult_operand_a_i;
  logic [data_w-1:0]     mult_operand_b_i;
  logic                  csr_access_i;
  logic                  lsu_en_i;
  logic                  lsu_ready_ex_i;
  logic                  branch_in_ex_i;
  logic                  wb_ready_i;
  logic [data_w-1:0]     csr_rdata_i;
  logic [data_w-1:0]     lsu_rdata_i;
  logic                  regfile_alu_we_i;
  logic                  regfile_we_i;
  logic [reg_addr_w-1:0] regfile_alu_waddr_i;
  logic [reg_addr_w-1:0] regfile_waddr_i;
  logic                  regfile_alu_we_fw_o;
  logic                  regfile_we_wb_o;
  logic [reg_addr_w-1:0] regfile_alu_waddr_fw_o;
  logic [reg_addr_w-1:0] regfile_waddr_wb_o;
  logic [data_w-1:0]     regfile_alu_wdata_fw_o;
  logic [data_w-1:0]     regfile_wdata_wb_o;
  logic [data_w-1:0]     jump_target_o;
  logic                  branch_decision_o;
  logic                  mult_multicycle_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;

  // Expected stage state
  logic                  exp_high;
  logic                  exp_we;
  logic [reg_addr_w-1:0] exp_waddr;
  logic                  exp_units_ready;
  logic                  exp_ready;
  logic                  exp_valid;
  logic [31:0]           lcg_state = 32'h96c2;

  ex_stage i_dut (.*);

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference sequencing
  //////////////////////////////////////////////////////////////////////

  // High word issue stalls only while not yet in HIGH
  assign exp_units_ready = (exp_high || !(mult_en_i && mult_operator_i != MUL)) &&
                           lsu_ready_ex_i && wb_ready_i;
  assign exp_ready = exp_units_ready || branch_in_ex_i;
  assign exp_valid = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && exp_units_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_high  <= 1'b0;
      exp_we    <= 1'b0;
      exp_waddr <= '0;
    end else begin
      if (!exp_high && mult_en_i && mult_operator_i != MUL) begin
        exp_high <= 1'b1;
      end else if (exp_high && exp_ready) begin
        exp_high <= 1'b0;
      end
      // Slot loads on acceptance, drains when write-back is free
      if (exp_valid) begin
        exp_we <= regfile_we_i;
        if (regfile_we_i) begin
          exp_waddr <= regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        exp_we <= 1'b0;
      end
    end
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("error at time %0t: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks sampled on the falling edge where everything is settled
  //////////////////////////////////////////////////////////////////////

  a_reset: assert property (@(negedge clk) !rst_n |->
    !regfile_we_wb_o && !mult_multicycle_o && ex_valid_o == exp_valid)
    else report_mismatch("state or valid wrong during reset");
  a_alu: assert property (@(negedge clk) disable iff (!rst_n)
    alu_en_i && !mult_en_i && !csr_access_i |->
    regfile_alu_wdata_fw_o == alu_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i))
    else report_mismatch("forwarded ALU result differs from reference");
  a_branch: assert property (@(negedge clk)
    branch_decision_o == cmp_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i) &&
    jump_target_o == alu_operand_c_i)
    else report_mismatch("branch decision or jump target wrong");
  a_mul_low: assert property (@(negedge clk) disable iff (!rst_n)
    mult_en_i && mult_operator_i == MUL && !csr_access_i && !exp_high &&
    lsu_ready_ex_i && wb_ready_i |-> ex_ready_o &&
    regfile_alu_wdata_fw_o == mult_ref(MUL, mult_operand_a_i, mult_operand_b_i))
    else report_mismatch("MUL low word wrong or stage not ready");
  a_high_issue: assert property (@(negedge clk) disable iff (!rst_n)
    mult_en_i && mult_operator_i != MUL && !exp_high && !branch_in_ex_i |-> !ex_ready_o)
    else report_mismatch("ex_ready_o high in high word issue cycle");
  a_high_word: assert property (@(negedge clk) disable iff (!rst_n)
    exp_high && !csr_access_i |-> (mult_multicycle_o || !ex_ready_o) &&
    regfile_alu_wdata_fw_o == mult_ref(mult_operator_i, mult_operand_a_i, mult_operand_b_i))
    else report_mismatch("high word result differs from reference");
  a_csr: assert property (@(negedge clk) disable iff (!rst_n)
    csr_access_i |-> regfile_alu_wdata_fw_o == csr_rdata_i)
    else report_mismatch("CSR data lost forwarding priority");
  a_idle_fw: assert property (@(negedge clk) disable iff (!rst_n)
    !(csr_access_i || mult_en_i || alu_en_i) |-> regfile_alu_wdata_fw_o == '0)
    else report_mismatch("forwarded data not zero with no unit enabled");
  a_ports: assert property (@(negedge clk) regfile_alu_we_fw_o == regfile_alu_we_i &&
    regfile_alu_waddr_fw_o == regfile_alu_waddr_i && regfile_wdata_wb_o == lsu_rdata_i)
    else report_mismatch("pass-through port differs from its input");
  a_control: assert property (@(negedge clk) disable iff (!rst_n)
    ex_ready_o == exp_ready && ex_valid_o == exp_valid && mult_multicycle_o == exp_high)
    else report_mismatch("stage ready, valid or multicycle wrong");
  a_exwb: assert property (@(negedge clk)
    regfile_we_wb_o == exp_we && regfile_waddr_wb_o == exp_waddr)
    else report_mismatch("EX/WB register content wrong");
  a_stall: assert property (@(negedge clk) disable iff (!rst_n)
    !(wb_ready_i && lsu_ready_ex_i) |-> !ex_valid_o && ex_ready_o == branch_in_ex_i)
    else report_mismatch("back-pressure did not stall the stage");
  a_hold: assert property (@(negedge clk) disable iff (!rst_n)
    $past(!wb_ready_i) |-> $stable(regfile_we_wb_o) && $stable(regfile_waddr_wb_o))
    else report_mismatch("write-back outputs moved under back-pressure");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] random_word();
    lcg_state = lcg_next(lcg_state);
    return lcg_state;
  endfunction

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic clear_inputs();
    alu_en_i            = 1'b0;
    alu_operator_i      = ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  // Register addresses, load data and an occasional CSR read
  task automatic randomize_side();
    logic [31:0] w;
    w = random_word();
    regfile_we_i        = w[31];
    regfile_alu_we_i    = w[30];
    lsu_en_i            = w[29];
    csr_access_i        = (w[28:26] == 3'b000);
    branch_in_ex_i      = w[25];
    regfile_waddr_i     = w[5:0];
    regfile_alu_waddr_i = w[13:8];
    lsu_rdata_i         = random_word();
    csr_rdata_i         = random_word();
  endtask

  // Bounded wait for the stage to accept
  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!ex_ready_o && n < 20);
    if (!ex_ready_o) begin
      abort_run("ex_ready_o stayed low for 20 cycles");
    end
  endtask

  initial begin
    rst_n = 1'b0;
    clear_inputs();
    // Enables toggle in reset while the EX/WB slot stays empty
    for (int i = 0; i < 16; i++) begin
      next_cycle();
      alu_en_i     = i[0];
      lsu_en_i     = i[1];
      regfile_we_i = 1'b1;
    end
    rst_n = 1'b1;
    clear_inputs();

    // Every ALU operator in turn
    for (int i = 0; i < 200; i++) begin
      next_cycle();
      randomize_side();
      alu_en_i        = 1'b1;
      alu_operator_i  = alu_op_e'(i[3:0]);
      alu_operand_a_i = random_word();
      alu_operand_b_i = (i % 5 == 0) ? alu_operand_a_i : random_word();
      alu_operand_c_i = random_word();
    end

    // Single cycle MUL
    for (int i = 0; i < 20; i++) begin
      next_cycle();
      randomize_side();
      alu_en_i         = 1'b0;
      mult_en_i        = 1'b1;
      mult_operator_i  = MUL;
      mult_operand_a_i = random_word();
      mult_operand_b_i = random_word();
    end

    // High word operators with sign corners in the first round
    for (int r = 0; r < 8; r++) begin
      for (int k = 1; k < 4; k++) begin
        next_cycle();
        randomize_side();
        csr_access_i     = 1'b0;
        branch_in_ex_i   = 1'b0;
        mult_en_i        = 1'b1;
        mult_operator_i  = mult_op_e'(k[1:0]);
        mult_operand_a_i = (r == 0) ? 32'h8000_0000 : random_word();
        mult_operand_b_i = (r == 0) ? 32'hffff_ffff : random_word();
        wait_ready();
      end
    end

    // Write-back stall followed by a branch while stalled and an LSU stall
    next_cycle();
    clear_inputs();
    alu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = 6'h2a;
    wb_ready_i      = 1'b0;
    repeat (3) next_cycle();
    branch_in_ex_i = 1'b1;
    next_cycle();
    branch_in_ex_i = 1'b0;
    wb_ready_i     = 1'b1;
    lsu_ready_ex_i = 1'b0;
    next_cycle();
    lsu_ready_ex_i = 1'b1;

    // High word held in HIGH while write-back is busy
    next_cycle();
    clear_inputs();
    mult_en_i        = 1'b1;
    mult_operator_i  = MULHSU;
    mult_operand_a_i = random_word();
    mult_operand_b_i = random_word();
    wb_ready_i       = 1'b0;
    repeat (3) next_cycle();
    wb_ready_i = 1'b1;
    wait_ready();
    next_cycle();
    clear_inputs();
    next_cycle();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
